// ==== hw/exu_alu.sv ====
`timescale 1ns/1ps

module exu_alu (
   input  exu_cfg_pkg::alu_req_t req,
   output exu_cfg_pkg::gr_t      res
);

   import exu_cfg_pkg::*;
   import exu_op_pkg::*;

   gr_t            a;
   gr_t            b;
   logic           sub_op;
   gr_t            b_add;
   logic [grlen:0] sum;
   logic           carry;
   logic           lt_s;
   logic           lt_u;
   logic [4:0]     shamt;
   gr_t            sll_res;
   gr_t            srl_res;
   gr_t            sra_res;
   gr_t            lu12i_res;

   assign a = req.a;
   assign b = req.b;

   // sub and both compares share the adder
   assign sub_op = (req.op == alu_sub) || (req.op == alu_slt) || (req.op == alu_sltu);
   assign b_add  = sub_op ? ~b : b;

   assign sum   = {1'b0, a} + {1'b0, b_add} + {{grlen{1'b0}}, sub_op};
   assign carry = sum[grlen];

   // signs differ: a negative means a < b
   assign lt_s = (a[grlen-1] != b[grlen-1]) ? a[grlen-1] : sum[grlen-1];
   // no carry out of a - b means borrow
   assign lt_u = ~carry;

   assign shamt = b[4:0];

   assign sll_res = a << shamt;
   assign srl_res = a >> shamt;
   assign sra_res = gr_t'($signed(a) >>> shamt);

   assign lu12i_res = {b[grlen-13:0], 12'b0};

   always_comb begin
      case (req.op)
         alu_add: begin
            res = sum[grlen-1:0];
         end
         alu_sub: begin
            res = sum[grlen-1:0];
         end
         alu_slt: begin
            res = {{(grlen-1){1'b0}}, lt_s};
         end
         alu_sltu: begin
            res = {{(grlen-1){1'b0}}, lt_u};
         end
         alu_and: begin
            res = a & b;
         end
         alu_or: begin
            res = a | b;
         end
         alu_xor: begin
            res = a ^ b;
         end
         alu_nor: begin
            res = ~(a | b);
         end
         alu_sll: begin
            res = sll_res;
         end
         alu_srl: begin
            res = srl_res;
         end
         alu_sra: begin
            res = sra_res;
         end
         alu_lu12i: begin
            res = lu12i_res;
         end
         default: begin
            // unused codes
            res = '0;
         end
      endcase
   end

endmodule

// ==== hw/exu_bru.sv ====
`timescale 1ns/1ps

module exu_bru (
   input  exu_cfg_pkg::bru_req_t req,
   output exu_cfg_pkg::bru_res_t res
);

   import exu_cfg_pkg::*;
   import exu_op_pkg::*;

   logic eq;
   logic lt_s;
   logic lt_u;
   logic cond;
   logic is_link;
   gr_t  base;

   assign eq   = (req.a == req.b);
   assign lt_s = ($signed(req.a) < $signed(req.b));
   assign lt_u = (req.a < req.b);

   always_comb begin
      case (req.op)
         bru_beq: begin
            cond = eq;
         end
         bru_bne: begin
            cond = ~eq;
         end
         bru_blt: begin
            cond = lt_s;
         end
         bru_bge: begin
            cond = ~lt_s;
         end
         bru_bltu: begin
            cond = lt_u;
         end
         bru_bgeu: begin
            cond = ~lt_u;
         end
         bru_b, bru_bl, bru_jirl: begin
            cond = 1'b1;
         end
         default: begin
            cond = 1'b0;
         end
      endcase
   end

   assign is_link = (req.op == bru_bl) || (req.op == bru_jirl);

   // jirl is register relative, the rest pc relative
   assign base = (req.op == bru_jirl) ? req.a : req.pc;

   assign res.taken    = req.valid & cond;
   assign res.target   = base + req.offset;
   assign res.link_wen = req.valid & is_link;
   assign res.link_pc  = req.pc + link_step;

endmodule

// ==== hw/exu_cfg_pkg.sv ====
package exu_cfg_pkg;

   localparam int grlen     = 32;
   localparam int reg_idx_w = 5;
   localparam int nregs     = 32;

   typedef logic [grlen-1:0]     gr_t;
   typedef logic [reg_idx_w-1:0] reg_idx_t;

   typedef struct packed {
      gr_t                 a;
      gr_t                 b;
      exu_op_pkg::alu_op_t op;
   } alu_req_t;

   typedef struct packed {
      logic                valid;
      exu_op_pkg::bru_op_t op;
      gr_t                 a;
      gr_t                 b;
      gr_t                 pc;
      gr_t                 offset;
   } bru_req_t;

   typedef struct packed {
      logic taken;
      gr_t  target;
      logic link_wen;
      gr_t  link_pc;
   } bru_res_t;

   // one register file write
   typedef struct packed {
      logic     wen;
      reg_idx_t rd;
      gr_t      data;
   } rf_wr_t;

endpackage

// ==== hw/exu_op_pkg.sv ====
package exu_op_pkg;

   // alu operation code
   typedef logic [3:0] alu_op_t;

   localparam alu_op_t alu_add   = 4'd0;
   localparam alu_op_t alu_sub   = 4'd1;
   localparam alu_op_t alu_slt   = 4'd2;
   localparam alu_op_t alu_sltu  = 4'd3;
   localparam alu_op_t alu_and   = 4'd4;
   localparam alu_op_t alu_or    = 4'd5;
   localparam alu_op_t alu_xor   = 4'd6;
   localparam alu_op_t alu_nor   = 4'd7;
   localparam alu_op_t alu_sll   = 4'd8;
   localparam alu_op_t alu_srl   = 4'd9;
   localparam alu_op_t alu_sra   = 4'd10;
   localparam alu_op_t alu_lu12i = 4'd11;

   // branch operation code, codes 9..15 never taken
   typedef logic [3:0] bru_op_t;

   localparam bru_op_t bru_beq  = 4'd0;
   localparam bru_op_t bru_bne  = 4'd1;
   localparam bru_op_t bru_blt  = 4'd2;
   localparam bru_op_t bru_bge  = 4'd3;
   localparam bru_op_t bru_bltu = 4'd4;
   localparam bru_op_t bru_bgeu = 4'd5;
   localparam bru_op_t bru_b    = 4'd6;
   localparam bru_op_t bru_bl   = 4'd7;
   localparam bru_op_t bru_jirl = 4'd8;

   // return address is the next sequential instruction
   localparam logic [31:0] link_step = 32'd4;

endpackage

// ==== hw/exu_rf.sv ====
`timescale 1ns/1ps

module exu_rf (
   input  logic                  clk,
   input  logic                  rst_n,
   input  exu_cfg_pkg::rf_wr_t   wr,
   input  exu_cfg_pkg::reg_idx_t rs1,
   input  exu_cfg_pkg::reg_idx_t rs2,
   output exu_cfg_pkg::gr_t      rs1_data,
   output exu_cfg_pkg::gr_t      rs2_data
);

   import exu_cfg_pkg::*;

   // r0 has no storage
   gr_t  regs [1:nregs-1];
   logic wr_ok;

   // r0 never takes a write
   assign wr_ok = wr.wen && (wr.rd != '0);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 1; i < nregs; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_ok) begin
         regs[wr.rd] <= wr.data;
      end
   end

   // no write-to-read bypass
   assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
   assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

   a_wr_known: assert property (
      @(posedge clk) disable iff (!rst_n)
      wr.wen |-> !$isunknown({wr.rd, wr.data})
   ) else $error("exu_rf: write with an unknown register index or data");

endmodule

// ==== hw/exu_top.sv ====
`timescale 1ns/1ps

module exu_top (
   input  logic                  clk,
   input  logic                  rst_n,

   input  logic                  valid,

   // alu
   input  exu_cfg_pkg::alu_req_t alu_req,
   input  logic                  alu_wen,
   input  exu_cfg_pkg::reg_idx_t rf_target,

   // bru
   input  exu_cfg_pkg::bru_req_t bru_req,

   // decode read ports
   input  exu_cfg_pkg::reg_idx_t rs1,
   input  exu_cfg_pkg::reg_idx_t rs2,
   output exu_cfg_pkg::gr_t      rs1_data,
   output exu_cfg_pkg::gr_t      rs2_data,

   // to fetch
   output logic                  br_taken,
   output exu_cfg_pkg::gr_t      brpc
);

   import exu_cfg_pkg::*;

   gr_t      alu_res;
   bru_res_t bru_res;
   rf_wr_t   rf_wr;

   exu_alu u_alu (
      .req       (alu_req   ),
      .res       (alu_res   )
   );

   exu_bru u_bru (
      .req       (bru_req   ),
      .res       (bru_res   )
   );

   exu_wb u_wb (
      .clk       (clk       ),
      .rst_n     (rst_n     ),
      .valid     (valid     ),
      .alu_wen   (alu_wen   ),
      .rf_target (rf_target ),
      .alu_res   (alu_res   ),
      .bru_res   (bru_res   ),
      .wr        (rf_wr     )
   );

   exu_rf u_rf (
      .clk       (clk       ),
      .rst_n     (rst_n     ),
      .wr        (rf_wr     ),
      .rs1       (rs1       ),
      .rs2       (rs2       ),
      .rs1_data  (rs1_data  ),
      .rs2_data  (rs2_data  )
   );

   // redirect goes out in the same cycle
   assign br_taken = bru_res.taken;
   assign brpc     = bru_res.target;

endmodule

// ==== hw/exu_wb.sv ====
`timescale 1ns/1ps

module exu_wb (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  valid,
   input  logic                  alu_wen,
   input  exu_cfg_pkg::reg_idx_t rf_target,
   input  exu_cfg_pkg::gr_t      alu_res,
   input  exu_cfg_pkg::bru_res_t bru_res,
   output exu_cfg_pkg::rf_wr_t   wr
);

   import exu_cfg_pkg::*;

   logic     alu_write;
   logic     wen_d;
   gr_t      data_d;
   logic     wen_q;
   reg_idx_t rd_q;
   gr_t      data_q;

   assign alu_write = valid & alu_wen;

   // link address has priority over the alu result
   assign wen_d  = bru_res.link_wen | alu_write;
   assign data_d = bru_res.link_wen ? bru_res.link_pc : alu_res;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wen_q <= 1'b0;
      end else begin
         wen_q <= wen_d;
      end
   end

   // payload only moves with a write
   always_ff @(posedge clk) begin
      if (wen_d) begin
         rd_q   <= rf_target;
         data_q <= data_d;
      end
   end

   assign wr.wen  = wen_q;
   assign wr.rd   = rd_q;
   assign wr.data = data_q;

   // decode never issues an alu write alongside a link
   a_one_writer: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(bru_res.link_wen && alu_write)
   ) else $error("exu_wb: alu and link write in the same cycle");

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module exu_tb -f sources.f -o exu_sim &&
./obj_dir/exu_sim | tee /dev/stderr | grep -q "^sim passed$" ||
{ echo "simulation did not pass"; exit 1; }

// ==== sources.f ====
hw/exu_op_pkg.sv
hw/exu_cfg_pkg.sv
hw/exu_alu.sv
hw/exu_bru.sv
hw/exu_wb.sv
hw/exu_rf.sv
hw/exu_top.sv
tests/exu_tb.sv

// ==== tests/exu_tb.sv ====
`timescale 1ns/1ps

module exu_tb;

   import exu_cfg_pkg::*;
   import exu_op_pkg::*;

   localparam int reset_cycles  = 8;
   localparam int reset_timeout = 20;
   localparam int n_alu         = 300;
   localparam int n_branch      = 300;
   localparam int n_link        = 40;
   localparam int n_nowrite     = 100;

   logic     clk;
   logic     rst_n;
   logic     valid;
   alu_req_t alu_req;
   logic     alu_wen;
   reg_idx_t rf_target;
   bru_req_t bru_req;
   reg_idx_t rs1;
   reg_idx_t rs2;
   gr_t      rs1_data;
   gr_t      rs2_data;
   logic     br_taken;
   gr_t      brpc;

   // expected register contents, fed through a two stage write pipe
   gr_t      shadow [nregs];
   logic     pend_wen;
   reg_idx_t pend_rd;
   gr_t      pend_data;
   logic     wb_wen;
   reg_idx_t wb_rd;
   gr_t      wb_data;
   reg_idx_t last_tgt;
   reg_idx_t old_tgt;

   string    test_name;
   logic     chk_en;
   int       err_cnt;
   gr_t      exp_rs1;
   gr_t      exp_rs2;
   bru_res_t exp_br;

   exu_top UUT (
      .clk       (clk       ),
      .rst_n     (rst_n     ),
      .valid     (valid     ),
      .alu_req   (alu_req   ),
      .alu_wen   (alu_wen   ),
      .rf_target (rf_target ),
      .bru_req   (bru_req   ),
      .rs1       (rs1       ),
      .rs2       (rs2       ),
      .rs1_data  (rs1_data  ),
      .rs2_data  (rs2_data  ),
      .br_taken  (br_taken  ),
      .brpc      (brpc      )
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   initial begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      #1;
      rst_n = 1'b1;
   end

   function automatic gr_t alu_ref(input alu_req_t r);
      gr_t res;
      case (r.op)
         alu_add:   res = r.a + r.b;
         alu_sub:   res = r.a - r.b;
         alu_slt:   res = ($signed(r.a) < $signed(r.b)) ? 32'd1 : 32'd0;
         alu_sltu:  res = (r.a < r.b) ? 32'd1 : 32'd0;
         alu_and:   res = r.a & r.b;
         alu_or:    res = r.a | r.b;
         alu_xor:   res = r.a ^ r.b;
         alu_nor:   res = ~(r.a | r.b);
         alu_sll:   res = r.a << r.b[4:0];
         alu_srl:   res = r.a >> r.b[4:0];
         alu_sra:   res = $signed(r.a) >>> r.b[4:0];
         alu_lu12i: res = r.b << 12;
         default:   res = '0;
      endcase
      return res;
   endfunction

   function automatic bru_res_t bru_ref(input bru_req_t r);
      bru_res_t res;
      logic     cond;
      case (r.op)
         bru_beq:  cond = (r.a == r.b);
         bru_bne:  cond = (r.a != r.b);
         bru_blt:  cond = ($signed(r.a) < $signed(r.b));
         bru_bge:  cond = ($signed(r.a) >= $signed(r.b));
         bru_bltu: cond = (r.a < r.b);
         bru_bgeu: cond = (r.a >= r.b);
         bru_b, bru_bl, bru_jirl: cond = 1'b1;
         default:  cond = 1'b0;
      endcase
      res.taken    = r.valid && cond;
      res.target   = (r.op == bru_jirl) ? r.a + r.offset : r.pc + r.offset;
      res.link_wen = r.valid && ((r.op == bru_bl) || (r.op == bru_jirl));
      res.link_pc  = r.pc + 32'd4;
      return res;
   endfunction

   function automatic gr_t rand_gr();
      return gr_t'($urandom);
   endfunction

   function automatic reg_idx_t rand_idx();
      return reg_idx_t'($urandom_range(nregs - 1, 0));
   endfunction

   function automatic alu_req_t rand_alu_req();
      alu_req_t r;
      r.a  = rand_gr();
      r.b  = rand_gr();
      // codes 12..15 included
      r.op = alu_op_t'($urandom_range(15, 0));
      return r;
   endfunction

   function automatic bru_req_t rand_bru_req(input bru_op_t op, input logic v);
      bru_req_t r;
      r.valid  = v;
      r.op     = op;
      r.a      = rand_gr();
      r.b      = rand_gr();
      // equal operands now and then
      if ($urandom_range(3, 0) == 0) begin
         r.b = r.a;
      end
      r.pc     = rand_gr() & 32'hffff_fffc;
      r.offset = rand_gr();
      return r;
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected) begin
         err_cnt++;
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
         $display("sim failed");
         $fatal(1, "value mismatch in %s", name);
      end
   endtask

   task automatic wait_for_reset();
      int cycles;
      cycles = 0;
      while (rst_n !== 1'b1 && cycles < reset_timeout) begin
         @(posedge clk);
         cycles++;
      end
      if (rst_n !== 1'b1) begin
         $display("reset was not released within %0d cycles", reset_timeout);
         $display("sim failed");
         $fatal(1, "timeout waiting for reset release");
      end
   endtask

   // write from two cycles back has landed at this edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
      if (wb_wen && wb_rd != '0) begin
         shadow[wb_rd] = wb_data;
      end
      wb_wen   = pend_wen;
      wb_rd    = pend_rd;
      wb_data  = pend_data;
      pend_wen = 1'b0;
   endtask

   task automatic apply_instr(input string name, input logic v, input alu_req_t areq,
                              input logic awen, input reg_idx_t tgt, input bru_req_t breq,
                              input reg_idx_t r1, input reg_idx_t r2);
      gr_t      alu_exp;
      bru_res_t br_exp;
      next_cycle();
      valid     = v;
      alu_req   = areq;
      alu_wen   = awen;
      rf_target = tgt;
      bru_req   = breq;
      rs1       = r1;
      rs2       = r2;
      alu_exp   = alu_ref(areq);
      br_exp    = bru_ref(breq);
      test_name = name;
      exp_rs1   = shadow[r1];
      exp_rs2   = shadow[r2];
      exp_br    = br_exp;
      if (br_exp.link_wen) begin
         pend_wen  = 1'b1;
         pend_rd   = tgt;
         pend_data = br_exp.link_pc;
      end else if (v && awen) begin
         pend_wen  = 1'b1;
         pend_rd   = tgt;
         pend_data = alu_exp;
      end
      old_tgt  = last_tgt;
      last_tgt = tgt;
      chk_en   = 1'b1;
   endtask

   // outputs are stable by the falling edge
   always @(negedge clk) begin
      if (chk_en) begin
         check({test_name, " rs1_data"}, exp_rs1, rs1_data);
         check({test_name, " rs2_data"}, exp_rs2, rs2_data);
         check({test_name, " br_taken"}, {31'b0, exp_br.taken}, {31'b0, br_taken});
         if (exp_br.taken) begin
            check({test_name, " brpc"}, exp_br.target, brpc);
         end
      end
   end

   initial begin
      bru_req_t breq;
      reg_idx_t tgt;
      int       mode;
      void'($urandom(32'h236));
      valid     = 1'b0;
      alu_req   = '0;
      alu_wen   = 1'b0;
      rf_target = '0;
      bru_req   = '0;
      rs1       = '0;
      rs2       = '0;
      test_name = "idle";
      chk_en    = 1'b0;
      err_cnt   = 0;
      exp_rs1   = '0;
      exp_rs2   = '0;
      exp_br    = '0;
      pend_wen  = 1'b0;
      pend_rd   = '0;
      pend_data = '0;
      wb_wen    = 1'b0;
      wb_rd     = '0;
      wb_data   = '0;
      last_tgt  = '0;
      old_tgt   = '0;
      for (int i = 0; i < nregs; i++) begin
         shadow[i] = '0;
      end

      wait_for_reset();

      for (int i = 0; i < nregs; i += 2) begin
         apply_instr("reset", 1'b0, '0, 1'b0, '0, '0, reg_idx_t'(i), reg_idx_t'(i + 1));
      end

      for (int i = 0; i < n_alu; i++) begin
         breq = rand_bru_req(bru_op_t'($urandom_range(15, 0)), 1'b0);
         apply_instr("alu_write", 1'b1, rand_alu_req(), 1'b1, rand_idx(), breq,
                     old_tgt, rand_idx());
      end

      // all sixteen codes, valid low about one time in eight
      for (int i = 0; i < n_branch; i++) begin
         breq = rand_bru_req(bru_op_t'($urandom_range(15, 0)), $urandom_range(7, 0) != 0);
         apply_instr("branch", 1'b1, rand_alu_req(), 1'b0, rand_idx(), breq,
                     old_tgt, rand_idx());
      end

      for (int i = 0; i < n_link; i++) begin
         breq = rand_bru_req(($urandom_range(1, 0) == 0) ? bru_bl : bru_jirl, 1'b1);
         tgt  = reg_idx_t'($urandom_range(nregs - 1, 1));
         apply_instr("link_write", 1'b1, rand_alu_req(), 1'b0, tgt, breq,
                     old_tgt, rand_idx());
      end

      for (int i = 0; i < n_nowrite; i++) begin
         mode = $urandom_range(2, 0);
         breq = rand_bru_req(bru_op_t'($urandom_range(15, 0)), 1'b0);
         if (mode == 0) begin
            apply_instr("valid_low", 1'b0, rand_alu_req(), 1'b1, rand_idx(), breq,
                        old_tgt, rand_idx());
         end else if (mode == 1) begin
            apply_instr("wen_low", 1'b1, rand_alu_req(), 1'b0, rand_idx(), breq,
                        old_tgt, rand_idx());
         end else begin
            apply_instr("r0_write", 1'b1, rand_alu_req(), 1'b1, '0, breq,
                        old_tgt, '0);
         end
      end

      // final sweep over the whole file
      for (int i = 0; i < nregs; i += 2) begin
         apply_instr("final_read", 1'b0, '0, 1'b0, '0, '0, reg_idx_t'(i), reg_idx_t'(i + 1));
      end

      next_cycle();
      chk_en = 1'b0;
      if (err_cnt == 0) begin
         $display("sim passed");
         $finish;
      end else begin
         $display("sim failed");
         $fatal(1, "%0d checks did not match", err_cnt);
      end
   end

endmodule
